/* design/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0] word_t;

    localparam word_t RESET_PC = 32'h8000_0000;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // field views of one instruction word, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_s;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_s;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_s;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_s;

    typedef union packed {
        r_fmt_s r_fmt;
        i_fmt_s i_fmt;
        s_fmt_s s_fmt;
        b_fmt_s b_fmt;
        u_fmt_s u_fmt;
        j_fmt_s j_fmt;
    } inst_u;

    typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} alu_op_e;

    typedef enum logic [1:0] {REG, PC, ZERO} src_a_e;

    typedef enum logic [1:0] {ALU, LOAD, LINK} wb_sel_e;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        word_t                 imm;
        alu_op_e               alu_op;
        src_a_e                src_a;
        logic                  use_imm;  // operand b from imm
        logic                  branch;
        logic [2:0]            funct3;   // branch condition
        logic                  jump;
        logic                  jalr;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
        wb_sel_e               wb_sel;
    } ctrl_s;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
        logic  re;
    } dmem_req_s;

endpackage

/* design/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  redirect,
    input  word_t redirect_target,
    output word_t pc,
    output word_t pc_plus4
);

    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_target;  // taken branch or jump
        end else begin
            pc <= pc_plus4;
        end
    end

endmodule

/* design/decoder.sv */
`timescale 1ns/1ps

module decoder
    import rv_pkg::*;
(
    input  inst_u inst,
    output ctrl_s ctrl
);

    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;
    alu_op_e fn_op;
    logic    is_reg;

    assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
    assign imm_b = {{20{inst.b_fmt.imm12}}, inst.b_fmt.imm11, inst.b_fmt.imm10_5,
                    inst.b_fmt.imm4_1, 1'b0};
    assign imm_u = {inst.u_fmt.imm, 12'b0};
    assign imm_j = {{12{inst.j_fmt.imm20}}, inst.j_fmt.imm19_12, inst.j_fmt.imm11,
                    inst.j_fmt.imm10_1, 1'b0};

    assign is_reg = (inst.r_fmt.opcode == OP_REG);

    always_comb begin
        case (inst.r_fmt.funct3)
            3'b000:  fn_op = (is_reg && inst.r_fmt.funct7[5]) ? SUB : ADD;  // no subi
            3'b001:  fn_op = SLL;
            3'b010:  fn_op = SLT;
            3'b011:  fn_op = SLTU;
            3'b100:  fn_op = XOR;
            3'b101:  fn_op = inst.r_fmt.funct7[5] ? SRA : SRL;
            3'b110:  fn_op = OR;
            default: fn_op = AND;
        endcase
    end

    always_comb begin
        ctrl        = '0;  // unknown opcode writes nothing
        ctrl.rd     = inst.r_fmt.rd;
        ctrl.rs1    = inst.r_fmt.rs1;
        ctrl.rs2    = inst.r_fmt.rs2;
        ctrl.funct3 = inst.r_fmt.funct3;
        ctrl.alu_op = ADD;
        ctrl.src_a  = REG;
        ctrl.wb_sel = ALU;
        case (inst.r_fmt.opcode)
            OP_LUI: begin
                ctrl.imm = imm_u; ctrl.src_a = ZERO; ctrl.use_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_AUIPC: begin
                ctrl.imm = imm_u; ctrl.src_a = PC; ctrl.use_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_JAL: begin
                ctrl.imm = imm_j; ctrl.src_a = PC; ctrl.use_imm = 1'b1;
                ctrl.jump = 1'b1; ctrl.reg_write = 1'b1; ctrl.wb_sel = LINK;
            end
            OP_JALR: begin
                ctrl.imm = imm_i; ctrl.use_imm = 1'b1; ctrl.jump = 1'b1; ctrl.jalr = 1'b1;
                ctrl.reg_write = 1'b1; ctrl.wb_sel = LINK;
            end
            OP_BRANCH: begin
                ctrl.imm = imm_b; ctrl.branch = 1'b1;
            end
            OP_LOAD: begin
                ctrl.imm = imm_i; ctrl.use_imm = 1'b1; ctrl.wb_sel = LOAD;
                ctrl.mem_read = (inst.r_fmt.funct3 == 3'b010);  // lw only
                ctrl.reg_write = (inst.r_fmt.funct3 == 3'b010);
            end
            OP_STORE: begin
                ctrl.imm = imm_s; ctrl.use_imm = 1'b1;
                ctrl.mem_write = (inst.r_fmt.funct3 == 3'b010);  // sw only
            end
            OP_IMM: begin
                ctrl.imm = imm_i; ctrl.use_imm = 1'b1; ctrl.alu_op = fn_op;
                ctrl.reg_write = 1'b1;
            end
            OP_REG: begin
                ctrl.alu_op = fn_op; ctrl.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  word_t                 wdata,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output word_t                 rdata1,
    output word_t                 rdata2
);

    word_t regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin  // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* design/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit
    import rv_pkg::*;
(
    input  ctrl_s ctrl,
    input  word_t pc,
    input  word_t rs1_data,
    input  word_t rs2_data,
    output word_t alu_result,
    output logic  redirect,
    output word_t redirect_target
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    logic       taken;

    always_comb begin
        case (ctrl.src_a)
            REG:     op_a = rs1_data;
            PC:      op_a = pc;  // auipc and jal
            default: op_a = '0;  // lui
        endcase
    end

    assign op_b  = ctrl.use_imm ? ctrl.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            SLL:     alu_result = op_a << shamt;
            SLT:     alu_result = word_t'($signed(op_a) < $signed(op_b));
            SLTU:    alu_result = word_t'(op_a < op_b);
            XOR:     alu_result = op_a ^ op_b;
            SRL:     alu_result = op_a >> shamt;
            SRA:     alu_result = word_t'($signed(op_a) >>> shamt);
            OR:      alu_result = op_a | op_b;
            AND:     alu_result = op_a & op_b;
            default: alu_result = '0;
        endcase
    end

    // branch condition straight from the register operands
    always_comb begin
        case (ctrl.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign redirect = ctrl.jump || (ctrl.branch && taken);

    // jalr target is rs1+imm with bit 0 dropped
    assign redirect_target = ctrl.jalr ? {alu_result[XLEN-1:1], 1'b0} : pc + ctrl.imm;

endmodule

/* design/mem_writeback.sv */
`timescale 1ns/1ps

module mem_writeback
    import rv_pkg::*;
(
    input  logic      reset,
    input  ctrl_s     ctrl,
    input  word_t     alu_result,
    input  word_t     rs2_data,
    input  word_t     pc_plus4,
    input  word_t     dmem_rdata,
    output dmem_req_s dmem_req,
    output logic      rd_we,
    output word_t     rd_wdata
);

    // address is rs1+imm from the alu
    assign dmem_req.addr  = alu_result;
    assign dmem_req.wdata = rs2_data;
    assign dmem_req.we    = ctrl.mem_write && !reset;
    assign dmem_req.re    = ctrl.mem_read && !reset;

    always_comb begin
        case (ctrl.wb_sel)
            LOAD:    rd_wdata = dmem_rdata;
            LINK:    rd_wdata = pc_plus4;  // return address
            default: rd_wdata = alu_result;
        endcase
    end

    assign rd_we = ctrl.reg_write && !reset;

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output dmem_req_s dmem_req,
    input  word_t     dmem_rdata
);

    word_t pc_plus4;
    ctrl_s ctrl;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_result;
    logic  redirect;
    word_t redirect_target;
    logic  rd_we;
    word_t rd_wdata;

    fetch_unit fetch_unit_inst (
        .clk             (clk),
        .reset           (reset),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .pc              (imem_addr),  // pc drives the fetch port directly
        .pc_plus4        (pc_plus4)
    );

    decoder decoder_inst (
        .inst (imem_data),
        .ctrl (ctrl)
    );

    reg_file reg_file_inst (
        .clk    (clk),
        .we     (rd_we),
        .waddr  (ctrl.rd),
        .wdata  (rd_wdata),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exec_unit exec_unit_inst (
        .ctrl            (ctrl),
        .pc              (imem_addr),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .alu_result      (alu_result),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    mem_writeback mem_writeback_inst (
        .reset      (reset),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .pc_plus4   (pc_plus4),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .rd_we      (rd_we),
        .rd_wdata   (rd_wdata)
    );

endmodule

/* dv/rv_asm.svh */
`ifndef RV_ASM_SVH
`define RV_ASM_SVH

localparam word_t LCG_MUL = 32'd1664525;
localparam word_t LCG_INC = 32'd1013904223;

function automatic word_t lcg_next(word_t state);
    return state * LCG_MUL + LCG_INC;
endfunction

function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                 logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                 logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};  // sw only
endfunction

function automatic word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                 logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic word_t u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic word_t j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

`endif

/* dv/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb
    import rv_pkg::*;
();

    `include "rv_asm.svh"

    localparam int    RESET_CYCLES = 5;
    localparam int    IMEM_WORDS   = 256;
    localparam word_t NOP          = 32'h0000_0013;  // addi x0, x0, 0
    localparam word_t DONE_ADDR    = 32'h0000_07fc;  // end-of-program marker store

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_s dmem_req;
    word_t     dmem_rdata;
    word_t     imem [IMEM_WORDS];
    word_t     dmem [512];
    word_t     imem_idx;
    word_t     prog[$];
    word_t     exp_pc[$];
    word_t     exp_addr[$];
    word_t     exp_data[$];
    word_t     exp_ld[$];
    word_t     pc_trace[$];
    word_t     st_addr[$];
    word_t     st_data[$];
    word_t     ld_addr[$];
    word_t     rng = 32'd90;
    logic      done = 1'b0;
    int        cycles = 0;
    int        budget = 0;

    rv_core rv_core_inst (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign imem_idx   = (imem_addr - RESET_PC) >> 2;
    assign imem_data  = (imem_idx < IMEM_WORDS) ? imem[imem_idx[7:0]] : NOP;
    assign dmem_rdata = dmem[dmem_req.addr[10:2]];

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(string name, word_t got, word_t exp);
        assert (got === exp) else
            fail_now($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    // data memory, store and load traces, retired pc trace
    always @(posedge clk) begin
        cycles++;
        if (cycles > budget) fail_now("timeout: program did not reach its end marker");
        if (!reset) pc_trace.push_back(imem_addr);
        if (dmem_req.re) ld_addr.push_back(dmem_req.addr);
        if (dmem_req.we) begin
            dmem[dmem_req.addr[10:2]] <= dmem_req.wdata;
            if (dmem_req.addr == DONE_ADDR) begin
                done = 1'b1;
            end else begin
                st_addr.push_back(dmem_req.addr);
                st_data.push_back(dmem_req.wdata);
            end
        end
    end

    always @(negedge clk) begin
        if (reset) begin
            assert (!dmem_req.we && !dmem_req.re) else
                fail_now("data memory request active while reset is high");
        end
    end

    function automatic word_t next_rand();
        rng = lcg_next(rng);
        return rng;
    endfunction

    function automatic word_t next_pc();
        return RESET_PC + 32'(prog.size() * 4);
    endfunction

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic start_program();
        prog.delete();
        exp_pc.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_ld.delete();
    endtask

    task automatic emit(word_t w);
        exp_pc.push_back(next_pc());
        prog.push_back(w);
    endtask

    task automatic skipped_nops(int n);
        repeat (n) begin
            prog.push_back(NOP);  // jumped over and never retired
        end
    endtask

    task automatic load_const(logic [4:0] rd, word_t value);
        word_t hi;
        hi = value + 32'h800;  // addi sign-extends the low part
        emit(u_type(hi[31:12], rd, OP_LUI));
        emit(i_type(value[11:0], rd, 3'd0, rd, OP_IMM));
    endtask

    task automatic store_expect(logic [4:0] rs2, logic [11:0] off, word_t value);
        emit(s_type(off, rs2, 5'd0));
        exp_addr.push_back({{20{off[11]}}, off});
        exp_data.push_back(value);
    endtask

    task automatic load_expect(logic [4:0] rd, logic [11:0] off);
        emit(i_type(off, 5'd0, 3'b010, rd, OP_LOAD));
        exp_ld.push_back({{20{off[11]}}, off});
    endtask

    task automatic run_program();
        emit(s_type(DONE_ADDR[11:0], 5'd0, 5'd0));
        prog.push_back(j_type(21'd0, 5'd0));  // spin until the next reset
        budget += 2 * (prog.size() + RESET_CYCLES);
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        foreach (imem[i]) imem[i] = (i < prog.size()) ? prog[i] : NOP;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        pc_trace.delete();
        st_addr.delete();
        st_data.delete();
        ld_addr.delete();
        done = 1'b0;
        reset <= 1'b0;
        wait (done);
        @(negedge clk);
        check_eq("store count", word_t'(st_addr.size()), word_t'(exp_addr.size()));
        foreach (exp_addr[i]) begin
            check_eq("dmem_req.addr", st_addr[i], exp_addr[i]);
            check_eq("dmem_req.wdata", st_data[i], exp_data[i]);
        end
        check_eq("load count", word_t'(ld_addr.size()), word_t'(exp_ld.size()));
        foreach (exp_ld[i]) check_eq("dmem_req.addr", ld_addr[i], exp_ld[i]);
        foreach (exp_pc[i]) check_eq("imem_addr", pc_trace[i], exp_pc[i]);
    endtask

    task automatic reset_and_fetch();
        start_program();
        imem[0] = s_type(12'h048, 5'd0, 5'd0);  // store seen at RESET_PC before the program loads
        load_expect(5'd1, 12'h040);  // held at RESET_PC during reset
        store_expect(5'd0, 12'h044, '0);
        for (int i = 2; i < 7; i++) emit(i_type(12'(i), 5'd0, 3'd0, 5'(i), OP_IMM));
        run_program();
    endtask

    task automatic alu_ops();
        word_t       a;
        word_t       b;
        logic [11:0] imm;
        logic [11:0] off;
        a = next_rand();
        b = next_rand();
        off = 12'h0;
        start_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 1 && f3 != 0 && f3 != 5) continue;
                emit(r_type({1'b0, alt[0], 5'b0}, 5'd2, 5'd1, f3[2:0], 5'd3));
                store_expect(5'd3, off, alu_ref(f3[2:0], alt[0], a, b));
                off += 12'd4;
                if (f3 == 0 && alt == 1) continue;  // there is no subi
                imm = 12'(next_rand());
                if (f3 == 1 || f3 == 5) imm[11:5] = {1'b0, alt[0], 5'b0};
                emit(i_type(imm, 5'd1, f3[2:0], 5'd4, OP_IMM));
                store_expect(5'd4, off, alu_ref(f3[2:0], alt[0], a, {{20{imm[11]}}, imm}));
                off += 12'd4;
            end
        end
        run_program();
    endtask

    task automatic x0_discard();
        start_program();
        load_const(5'd1, next_rand());
        emit(u_type(20'habcde, 5'd0, OP_LUI));
        emit(i_type(12'h123, 5'd1, 3'd0, 5'd0, OP_IMM));
        emit(r_type(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
        store_expect(5'd0, 12'h010, '0);
        run_program();
    endtask

    task automatic branch_conditions();
        word_t      v;
        word_t      a;
        word_t      b;
        logic [2:0] f3;
        start_program();
        for (int p = 0; p < 3; p++) begin
            v = next_rand();
            case (p)
                0: begin
                    a = v;
                    b = v;
                end
                1: begin  // signed lt
                    a = v | 32'h8000_0000;
                    b = v & 32'h7fff_ffff;
                end
                default: begin  // unsigned lt
                    a = v & 32'h7fff_ffff;
                    b = v | 32'h8000_0000;
                end
            endcase
            load_const(5'd1, a);
            load_const(5'd2, b);
            for (int k = 0; k < 6; k++) begin
                f3 = (k < 2) ? 3'(k) : 3'(k + 2);
                emit(b_type(13'd8, 5'd2, 5'd1, f3));
                emit(NOP);
                if (branch_ref(f3, a, b)) void'(exp_pc.pop_back());  // taken skips the nop
            end
        end
        run_program();
    endtask

    task automatic jumps_and_upper_imm();
        word_t pc;
        word_t target;
        start_program();
        emit(u_type(20'h12345, 5'd5, OP_LUI));
        store_expect(5'd5, 12'h000, 32'h1234_5000);
        pc = next_pc();
        emit(u_type(20'hfedcb, 5'd6, OP_AUIPC));
        store_expect(5'd6, 12'h004, pc + 32'hfedc_b000);
        pc = next_pc();
        emit(j_type(21'd12, 5'd7));
        skipped_nops(2);
        store_expect(5'd7, 12'h008, pc + 32'd4);
        pc = next_pc() + 32'd8;  // jalr sits after the two-word constant load
        target = pc + 32'd12;
        load_const(5'd8, target + 32'd4);
        emit(i_type(12'hffd, 5'd8, 3'd0, 5'd9, OP_JALR));  // odd sum drops its lsb
        skipped_nops(2);
        store_expect(5'd9, 12'h00c, pc + 32'd4);
        run_program();
    endtask

    task automatic load_store_round_trip();
        word_t       v;
        logic [11:0] off;
        start_program();
        for (int k = 0; k < 4; k++) begin
            v = next_rand();
            off = 12'h100 + 12'(k * 20);
            load_const(5'd10, v);
            store_expect(5'd10, off, v);
            load_expect(5'd11, off);
            store_expect(5'd11, off + 12'h200, v);
        end
        run_program();
    endtask

    initial begin
        reset = 1'b1;
        foreach (imem[i]) imem[i] = NOP;
        foreach (dmem[i]) dmem[i] = 32'hda7a_0000 ^ (i * 32'h0001_0004);
        reset_and_fetch();
        alu_ops();
        alu_ops();
        x0_discard();
        branch_conditions();
        jumps_and_upper_imm();
        load_store_round_trip();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* files.f */
+incdir+dv
design/rv_pkg.sv
design/fetch_unit.sv
design/decoder.sv
design/reg_file.sv
design/exec_unit.sv
design/mem_writeback.sv
design/rv_core.sv
dv/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/fetch_unit.sv
  - design/decoder.sv
  - design/reg_file.sv
  - design/exec_unit.sv
  - design/mem_writeback.sv
  - design/rv_core.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/rv_core_tb.sv
